//--- hw/epIsaPkg.sv
package epIsaPkg;

    // Instruction views, all 32 bits wide
    typedef struct packed {
        logic        isBranch;
        logic [2:0]  kind;
        logic [3:0]  cond;
        logic [3:0]  base;
        logic [19:0] offset;
    } branchViewT;

    typedef struct packed {
        logic [1:0]  cls;
        logic        store;
        logic        spare;
        logic [3:0]  base;
        logic [3:0]  target;
        logic [19:0] offset;
    } memViewT;

    typedef struct packed {
        logic [2:0]  cls;
        logic        orMode;
        logic [3:0]  dest;
        logic [3:0]  shift;
        logic [19:0] value;
    } directViewT;

    typedef struct packed {
        logic [3:0] cls;
        logic       immMode;
        logic [1:0] spare;
        logic [4:0] op;
        logic [3:0] dest;
        logic [3:0] termA;
        logic [3:0] termB;
        logic [7:0] imm;
    } aluViewT;

    typedef struct packed {
        logic [4:0]  cls;
        logic [2:0]  spare;
        logic [3:0]  dest;
        logic [3:0]  src;
        logic [15:0] unused;
    } moveViewT;

    typedef struct packed {
        logic [5:0]  cls;
        logic [5:0]  op;
        logic [19:0] data;
    } coreViewT;

    typedef union packed {
        branchViewT branchV;
        memViewT    memV;
        directViewT directV;
        aluViewT    aluV;
        moveViewT   moveV;
        coreViewT   coreV;
    } instWordT;

    localparam logic [2:0] brStandard = 3'b000;

    localparam logic [4:0] aluAdd   = 5'd0;
    localparam logic [4:0] aluSub   = 5'd1;
    localparam logic [4:0] aluAnd   = 5'd2;
    localparam logic [4:0] aluOr    = 5'd3;
    localparam logic [4:0] aluXor   = 5'd4;
    localparam logic [4:0] aluNot   = 5'd5;
    localparam logic [4:0] aluShl   = 5'd6;
    localparam logic [4:0] aluAsr   = 5'd7;
    localparam logic [4:0] aluLsr   = 5'd8;
    localparam logic [4:0] aluAndn  = 5'd11;
    localparam logic [4:0] aluSubNc = 5'd14;

    localparam logic [3:0] condAlways = 4'd0;
    localparam logic [3:0] condZ      = 4'd1;
    localparam logic [3:0] condNz     = 4'd2;
    localparam logic [3:0] condC      = 4'd3;
    localparam logic [3:0] condNc     = 4'd4;
    localparam logic [3:0] condN      = 4'd5;
    localparam logic [3:0] condNn     = 4'd6;
    localparam logic [3:0] condV      = 4'd7;
    localparam logic [3:0] condNv     = 4'd8;
    localparam logic [3:0] condHi     = 4'd9;
    localparam logic [3:0] condLs     = 4'd10;
    localparam logic [3:0] condGe     = 4'd11;
    localparam logic [3:0] condLt     = 4'd12;
    localparam logic [3:0] condGt     = 4'd13;
    localparam logic [3:0] condLe     = 4'd14;
    localparam logic [3:0] condNever  = 4'd15;

    localparam logic [5:0] coreHalt = 6'd2;

    // Class tests, checked from the top bit down
    function automatic logic isBranch(instWordT w);
        return w.branchV.isBranch;
    endfunction

    function automatic logic isMem(instWordT w);
        return w.memV.cls == 2'b01;
    endfunction

    function automatic logic isDirect(instWordT w);
        return w.directV.cls == 3'b001;
    endfunction

    function automatic logic isAlu(instWordT w);
        return w.aluV.cls == 4'b0001;
    endfunction

    function automatic logic isMove(instWordT w);
        return w.moveV.cls == 5'b00001;
    endfunction

    function automatic logic isCore(instWordT w);
        return w.coreV.cls == 6'b000001;
    endfunction

endpackage

//--- hw/epCorePkg.sv
package epCorePkg;

    // Sequencer states
    localparam logic [2:0] stIdle      = 3'd0;
    localparam logic [2:0] stFetch     = 3'd1;
    localparam logic [2:0] stDecode    = 3'd2;
    localparam logic [2:0] stExecute   = 3'd3;
    localparam logic [2:0] stMemory    = 3'd4;
    localparam logic [2:0] stWriteback = 3'd5;
    localparam logic [2:0] stHalt      = 3'd6;

    // Bit positions in the 4-bit flags vector
    localparam int flagV = 0;
    localparam int flagN = 1;
    localparam int flagZ = 2;
    localparam int flagC = 3;

endpackage

//--- hw/epRegFile.sv
`timescale 1ns/1ps

module epRegFile #(
    parameter int dataWidth = 32
) (
    input  logic                 iClk,
    input  logic [3:0]           rdAddrA,
    input  logic [3:0]           rdAddrB,
    output logic [dataWidth-1:0] rdDataA,
    output logic [dataWidth-1:0] rdDataB,
    input  logic                 wrEn,
    input  logic [3:0]           wrAddr,
    input  logic [dataWidth-1:0] wrData
);

    logic [dataWidth-1:0] regs [16];

    // Asynchronous reads
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge iClk) begin
        if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

//--- hw/epAlu.sv
`timescale 1ns/1ps

module epAlu
    import epIsaPkg::*;
    import epCorePkg::*;
#(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    input  logic [4:0]           op,
    input  logic                 carryIn,
    output logic [dataWidth-1:0] result,
    output logic [3:0]           flagsOut
);

    localparam int msb = dataWidth - 1;

    logic [dataWidth:0] wide;
    logic [dataWidth:0] carryExt;
    logic               overflow;

    assign carryExt = {{dataWidth{1'b0}}, carryIn};

    // Top bit of wide is carry or borrow
    always_comb begin
        case (op)
            aluAdd:   wide = {1'b0, opA} + {1'b0, opB} + carryExt;
            aluSub:   wide = {1'b0, opA} - ({1'b0, opB} + carryExt);
            aluAnd:   wide = {1'b0, opA & opB};
            aluOr:    wide = {1'b0, opA | opB};
            aluXor:   wide = {1'b0, opA ^ opB};
            aluNot:   wide = {1'b0, ~opA};
            aluShl:   wide = {1'b0, opA} << opB;
            aluAsr:   wide = {1'b0, $signed(opA) >>> opB};
            aluLsr:   wide = {1'b0, opA >> opB};
            aluAndn:  wide = {1'b0, opA & ~opB};
            aluSubNc: wide = {1'b0, opA} - {1'b0, opB};
            default:  wide = '0;
        endcase
    end

    assign result = wide[msb:0];

    // Signed overflow on add and subtract only
    always_comb begin
        case (op)
            aluAdd:           overflow = (opA[msb] == opB[msb]) && (result[msb] != opA[msb]);
            aluSub, aluSubNc: overflow = (opA[msb] != opB[msb]) && (result[msb] != opA[msb]);
            default:          overflow = 1'b0;
        endcase
    end

    always_comb begin
        flagsOut        = '0;
        flagsOut[flagC] = wide[dataWidth];
        flagsOut[flagZ] = result == '0;
        flagsOut[flagN] = result[msb];
        flagsOut[flagV] = overflow;
    end

endmodule

//--- hw/epSequencer.sv
`timescale 1ns/1ps

module epSequencer
    import epIsaPkg::*;
    import epCorePkg::*;
(
    input  logic        iClk,
    input  logic        rst,
    input  logic [31:0] rdData,
    input  logic [31:0] branchTarget,
    input  logic [3:0]  aluFlags,
    output instWordT    inst,
    output logic [2:0]  state,
    output logic [31:0] ip,
    output logic [3:0]  flags,
    output logic        halt
);

    logic [2:0] nextState;
    logic       isHalt;
    logic       condMet;
    logic       taken;
    logic       c;
    logic       z;
    logic       n;
    logic       v;

    assign c = flags[flagC];
    assign z = flags[flagZ];
    assign n = flags[flagN];
    assign v = flags[flagV];

    always_comb begin
        case (inst.branchV.cond)
            condAlways: condMet = 1'b1;
            condZ:      condMet = z;
            condNz:     condMet = !z;
            condC:      condMet = c;
            condNc:     condMet = !c;
            condN:      condMet = n;
            condNn:     condMet = !n;
            condV:      condMet = v;
            condNv:     condMet = !v;
            condHi:     condMet = c && !z;
            condLs:     condMet = !c || z;
            condGe:     condMet = n == v;
            condLt:     condMet = n != v;
            condGt:     condMet = !z && (n == v);
            condLe:     condMet = z || (n != v);
            condNever:  condMet = 1'b0;
            default:    condMet = 1'b0;
        endcase
    end

    // Other branch kinds fall through as no-ops
    assign taken = isBranch(inst) && (inst.branchV.kind == brStandard) && condMet;
    assign isHalt = isCore(inst) && (inst.coreV.op == coreHalt);
    assign halt = state == stHalt;

    always_comb begin
        case (state)
            stIdle:      nextState = stFetch;
            stFetch:     nextState = stDecode;
            stDecode:    nextState = stExecute;
            stExecute:   nextState = stMemory;
            stMemory:    nextState = stWriteback;
            stWriteback: nextState = isHalt ? stHalt : stFetch;
            stHalt:      nextState = stHalt;
            default:     nextState = stIdle;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge iClk) begin
        if (state == stFetch) begin
            inst <= rdData;
        end
    end

    // IP and flags commit at writeback
    always_ff @(posedge iClk) begin
        if (rst) begin
            ip    <= '0;
            flags <= '0;
        end else if (state == stWriteback) begin
            ip <= taken ? branchTarget : ip + 32'd1;
            if (isAlu(inst)) begin
                flags <= aluFlags;
            end
        end
    end

endmodule

//--- hw/epOperandPath.sv
`timescale 1ns/1ps

module epOperandPath
    import epIsaPkg::*;
    import epCorePkg::*;
#(
    parameter int dataWidth = 32
) (
    input  logic                 iClk,
    input  logic                 rst,
    input  instWordT             inst,
    input  logic [2:0]           state,
    input  logic [31:0]          ip,
    input  logic [3:0]           flags,
    input  logic [dataWidth-1:0] rdData,
    output logic [dataWidth-1:0] addr,
    output logic [dataWidth-1:0] wrData,
    output logic                 write,
    output logic [31:0]          branchTarget,
    output logic [3:0]           aluFlags
);

    logic [3:0]           rdAddrA;
    logic [3:0]           rdAddrB;
    logic [3:0]           wrAddr;
    logic                 wrEn;
    logic                 isLoad;
    logic                 isStore;
    logic [4:0]           aluOp;
    logic                 carryIn;
    logic [dataWidth-1:0] rdDataA;
    logic [dataWidth-1:0] rdDataB;
    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] wbData;
    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] regR;
    logic [dataWidth-1:0] regM;

    assign isLoad  = isMem(inst) && !inst.memV.store;
    assign isStore = isMem(inst) && inst.memV.store;

    // Register fields per class, ALU layout by default
    always_comb begin
        rdAddrA = inst.aluV.termA;
        rdAddrB = inst.aluV.termB;
        wrAddr  = inst.aluV.dest;
        if (isMem(inst)) begin
            rdAddrA = inst.memV.base;
            rdAddrB = inst.memV.target;
            wrAddr  = inst.memV.target;
        end else if (isDirect(inst)) begin
            rdAddrA = inst.directV.dest;
            wrAddr  = inst.directV.dest;
        end else if (isMove(inst)) begin
            rdAddrA = inst.moveV.src;
            wrAddr  = inst.moveV.dest;
        end
    end

    // Operand selection and immediate forming
    always_comb begin
        srcA = rdDataA;
        srcB = rdDataB;
        if (isBranch(inst)) begin
            srcA = dataWidth'(ip);
            srcB = {{(dataWidth-20){inst.branchV.offset[19]}}, inst.branchV.offset};
        end else if (isMem(inst)) begin
            srcB = dataWidth'(inst.memV.offset);
        end else if (isDirect(inst)) begin
            srcA = inst.directV.orMode ? rdDataA : '0;
            srcB = dataWidth'(inst.directV.value) << inst.directV.shift;
        end else if (isAlu(inst) && inst.aluV.immMode) begin
            srcB = dataWidth'(inst.aluV.imm) << {inst.aluV.termB, 1'b0};
        end else if (isMove(inst)) begin
            srcB = '0;
        end
    end

    // Non-ALU classes reuse the adder or the OR path
    assign aluOp   = isAlu(inst) ? inst.aluV.op :
                     ((isDirect(inst) || isMove(inst)) ? aluOr : aluAdd);
    assign carryIn = isAlu(inst) && flags[flagC];

    always_ff @(posedge iClk) begin
        if (state == stDecode) begin
            regA <= srcA;
            regB <= srcB;
            regM <= rdDataB;
        end else if (state == stMemory && isLoad) begin
            regM <= rdData;
        end
    end

    always_ff @(posedge iClk) begin
        if (rst) begin
            regR <= '0;
        end else if (state == stExecute) begin
            regR <= aluResult;
        end
    end

    assign wbData = isLoad ? regM : regR;
    assign wrEn   = (state == stWriteback) &&
                    (isAlu(inst) || isLoad || isDirect(inst) || isMove(inst));

    assign addr         = (state == stFetch) ? dataWidth'(ip) : regR;
    assign wrData       = regM;
    assign write        = (state == stMemory) && isStore;
    assign branchTarget = 32'(regR);

    epRegFile #(
        .dataWidth(dataWidth)
    ) u_epRegFile (
        .iClk   (iClk),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wbData)
    );

    epAlu #(
        .dataWidth(dataWidth)
    ) u_epAlu (
        .opA     (regA),
        .opB     (regB),
        .op      (aluOp),
        .carryIn (carryIn),
        .result  (aluResult),
        .flagsOut(aluFlags)
    );

endmodule

//--- hw/epCore.sv
`timescale 1ns/1ps

module epCore
    import epIsaPkg::*;
#(
    parameter int dataWidth = 32
) (
    input  logic                 iClk,
    input  logic                 rst,
    output logic [dataWidth-1:0] addr,
    input  logic [dataWidth-1:0] rdData,
    output logic [dataWidth-1:0] wrData,
    output logic                 write,
    output logic                 halt
);

    instWordT    inst;
    logic [2:0]  state;
    logic [31:0] ip;
    logic [31:0] branchTarget;
    logic [3:0]  flags;
    logic [3:0]  aluFlags;

    // Control and instruction fetch
    epSequencer u_epSequencer (
        .iClk        (iClk),
        .rst         (rst),
        .rdData      (32'(rdData)),
        .branchTarget(branchTarget),
        .aluFlags    (aluFlags),
        .inst        (inst),
        .state       (state),
        .ip          (ip),
        .flags       (flags),
        .halt        (halt)
    );

    epOperandPath #(
        .dataWidth(dataWidth)
    ) u_epOperandPath (
        .iClk        (iClk),
        .rst         (rst),
        .inst        (inst),
        .state       (state),
        .ip          (ip),
        .flags       (flags),
        .rdData      (rdData),
        .addr        (addr),
        .wrData      (wrData),
        .write       (write),
        .branchTarget(branchTarget),
        .aluFlags    (aluFlags)
    );

endmodule

//--- bench/epCore_chk.sv
`timescale 1ns/1ps

module epCore_chk (
    input logic iClk,
    input logic rst,
    input logic write,
    input logic halt
);

    // Store strobe lasts a single cycle
    singleWrite: assert property (@(posedge iClk) disable iff (rst) write |=> !write)
        else $error("write held high for two cycles in a row");

    haltQuiet: assert property (@(posedge iClk) disable iff (rst) !(write && halt))
        else $error("write raised while the core is halted");

    haltSticky: assert property (@(posedge iClk) disable iff (rst) halt |=> halt)
        else $error("halt dropped without a reset");

    resetQuiet: assert property (@(posedge iClk) rst |=> (!write && !halt))
        else $error("write or halt high in the cycle after reset");

endmodule

//--- bench/tbCore.sv
`timescale 1ns/1ps

module tbCore;

    localparam int dataWidth   = 32;
    localparam int memWords    = 1024;
    localparam int numPrograms = 20;
    localparam int randomLen   = 40;
    localparam int maxInstr    = 16 + randomLen + 16 + 1;
    localparam int watchdogNs  = numPrograms * 5 * maxInstr * 4 * 2;

    logic                 iClk = 1'b0;
    logic                 rst = 1'b1;
    logic [dataWidth-1:0] addr;
    logic [dataWidth-1:0] rdData;
    logic [dataWidth-1:0] wrData;
    logic                 write;
    logic                 halt;
    logic                 loadMem = 1'b0;
    logic [31:0]          mem [memWords];
    logic [31:0]          imageMem [memWords];
    logic [31:0]          expAddr [$];
    logic [31:0]          expData [$];
    logic [31:0]          expFetch [$];

    always #2 iClk = ~iClk;

    // Program and data memory, loaded whole while the core is in reset
    assign rdData = mem[addr[9:0]];

    always @(posedge iClk) begin
        if (loadMem) begin
            mem <= imageMem;
        end else if (write) begin
            mem[addr[9:0]] <= wrData;
        end
    end

    epCore #(
        .dataWidth(dataWidth)
    ) u_epCore (
        .iClk  (iClk),
        .rst   (rst),
        .addr  (addr),
        .rdData(rdData),
        .wrData(wrData),
        .write (write),
        .halt  (halt)
    );

    bind epCore epCore_chk u_epCoreChk (
        .iClk (iClk),
        .rst  (rst),
        .write(write),
        .halt (halt)
    );

    task automatic stopRun();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic valueError(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stopRun();
    endtask

    initial begin
        #(watchdogNs);
        $display("Timeout: the core did not finish all programs within %0d ns", watchdogNs);
        stopRun();
    end

    function automatic logic [31:0] fillWord(input int i);
        return (32'(i) * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
    endfunction

    function automatic logic [31:0] directWord(input logic orMode, input logic [3:0] dest,
                                               input logic [3:0] shift, input logic [19:0] value);
        return {3'b001, orMode, dest, shift, value};
    endfunction

    function automatic logic [31:0] memWord(input logic store, input logic [3:0] base,
                                            input logic [3:0] target, input logic [19:0] off);
        return {2'b01, store, 1'b0, base, target, off};
    endfunction

    function automatic logic [31:0] aluWord(input logic immMode, input logic [4:0] op,
                                            input logic [3:0] dest, input logic [3:0] termA,
                                            input logic [3:0] termB, input logic [7:0] imm);
        return {4'b0001, immMode, 2'b00, op, dest, termA, termB, imm};
    endfunction

    // r14 holds the data base and is never a destination
    function automatic logic [3:0] pickDest();
        logic [3:0] r;
        r = 4'($urandom % 15);
        return (r == 4'd14) ? 4'd15 : r;
    endfunction

    function automatic logic condHolds(input logic [3:0] cond, input logic c, input logic z,
                                       input logic n, input logic v);
        case (cond)
            4'd0:    return 1'b1;
            4'd1:    return z;
            4'd2:    return !z;
            4'd3:    return c;
            4'd4:    return !c;
            4'd5:    return n;
            4'd6:    return !n;
            4'd7:    return v;
            4'd8:    return !v;
            4'd9:    return c && !z;
            4'd10:   return !c || z;
            4'd11:   return n == v;
            4'd12:   return n != v;
            4'd13:   return !z && (n == v);
            4'd14:   return z || (n != v);
            default: return 1'b0;
        endcase
    endfunction

    task automatic aluModel(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
                            input logic cin, output logic [31:0] res, output logic co,
                            output logic vo);
        logic [32:0] sum;
        sum = '0;
        vo  = 1'b0;
        case (op)
            5'd0: begin
                sum = {1'b0, a} + {1'b0, b} + {32'b0, cin};
                vo  = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            5'd1, 5'd14: begin
                sum = {1'b0, a} - {1'b0, b} - ((op == 5'd1) ? {32'b0, cin} : 33'b0);
                vo  = (a[31] != b[31]) && (sum[31] != a[31]);
            end
            5'd2: sum[31:0] = a & b;
            5'd3: sum[31:0] = a | b;
            5'd4: sum[31:0] = a ^ b;
            5'd5: sum[31:0] = ~a;
            5'd6: sum = {1'b0, a} << b;
            5'd7: sum[31:0] = (b > 32'd31) ? {32{a[31]}} : 32'($signed(a) >>> b[4:0]);
            5'd8: sum[31:0] = (b > 32'd31) ? 32'd0 : (a >> b[4:0]);
            5'd11: sum[31:0] = a & ~b;
            default: sum = '0;
        endcase
        res = sum[31:0];
        co  = sum[32];
    endtask

    task automatic buildProgram();
        int pc;
        int kind;
        for (int i = 0; i < memWords; i++) begin
            imageMem[10'(i)] = fillWord(i);
        end
        pc = 0;
        for (int i = 0; i < 16; i++) begin
            if (i == 14) begin
                imageMem[10'(pc)] = directWord(1'b0, 4'd14, 4'd0, 20'd512);
            end else begin
                imageMem[10'(pc)] = directWord(1'b0, 4'(i), 4'($urandom % 13), 20'($urandom));
            end
            pc++;
        end
        for (int k = 0; k < randomLen; k++) begin
            kind = $urandom % 8;
            case (kind)
                0, 1: imageMem[10'(pc)] = directWord(kind == 1, pickDest(), 4'($urandom),
                                                      20'($urandom));
                2: imageMem[10'(pc)] = {5'b00001, 3'b000, pickDest(), 4'($urandom), 16'h0};
                3, 4: imageMem[10'(pc)] = aluWord(kind == 4, 5'($urandom % 16), pickDest(),
                                                   4'($urandom), 4'($urandom), 8'($urandom));
                // Forward only, at most six words ahead
                5: imageMem[10'(pc)] = {1'b1, 3'b000, 4'($urandom), 4'($urandom),
                                        20'(1 + $urandom % 6)};
                6: imageMem[10'(pc)] = memWord(1'b0, 4'd14, pickDest(), 20'($urandom % 512));
                default: imageMem[10'(pc)] = memWord(1'b1, 4'd14, 4'($urandom),
                                                     20'($urandom % 512));
            endcase
            pc++;
        end
        for (int i = 0; i < 16; i++) begin
            imageMem[10'(pc)] = memWord(1'b1, 4'd14, 4'(i), 20'(496 + i));
            pc++;
        end
        imageMem[10'(pc)] = {6'b000001, 6'd2, 20'd0};
    endtask

    // Instruction-set model, one instruction per loop pass
    task automatic runModel(output int count);
        logic [31:0] regs [16];
        logic [31:0] modelMem [memWords];
        logic [31:0] ip;
        logic [31:0] nextIp;
        logic [31:0] w;
        logic [31:0] ea;
        logic [31:0] opB;
        logic [31:0] res;
        logic        cf;
        logic        zf;
        logic        nf;
        logic        vf;
        logic        done;
        modelMem = imageMem;
        ip    = '0;
        cf    = 1'b0;
        zf    = 1'b0;
        nf    = 1'b0;
        vf    = 1'b0;
        done  = 1'b0;
        count = 0;
        while (!done && count < 2 * maxInstr) begin
            w = modelMem[ip[9:0]];
            expFetch.push_back(ip);
            count++;
            nextIp = ip + 32'd1;
            if (w[31]) begin
                if (w[30:28] == 3'd0 && condHolds(w[27:24], cf, zf, nf, vf)) begin
                    nextIp = ip + {{12{w[19]}}, w[19:0]};
                end
            end else if (w[31:30] == 2'b01) begin
                ea = regs[w[27:24]] + {12'b0, w[19:0]};
                if (w[29]) begin
                    expAddr.push_back(ea);
                    expData.push_back(regs[w[23:20]]);
                    modelMem[ea[9:0]] = regs[w[23:20]];
                end else begin
                    regs[w[23:20]] = modelMem[ea[9:0]];
                end
            end else if (w[31:29] == 3'b001) begin
                res = {12'b0, w[19:0]} << w[23:20];
                regs[w[27:24]] = w[28] ? (regs[w[27:24]] | res) : res;
            end else if (w[31:28] == 4'b0001) begin
                opB = w[27] ? ({24'b0, w[7:0]} << (2 * w[11:8])) : regs[w[11:8]];
                aluModel(w[24:20], regs[w[15:12]], opB, cf, res, cf, vf);
                zf = (res == 32'd0);
                nf = res[31];
                regs[w[19:16]] = res;
            end else if (w[31:27] == 5'b00001) begin
                regs[w[23:20]] = regs[w[19:16]];
            end else if (w[31:26] == 6'b000001 && w[25:20] == 6'd2) begin
                done = 1'b1;
            end
            ip = nextIp;
        end
    endtask

    task automatic runOnDut(input int prog, input int count);
        int haltCycle;
        haltCycle = 5 * count + 1;
        @(negedge iClk);
        loadMem = 1'b1;
        rst     = 1'b1;
        repeat (3) @(negedge iClk);
        loadMem = 1'b0;
        rst     = 1'b0;
        for (int cycle = 1; cycle <= haltCycle + 8; cycle++) begin
            @(negedge iClk);
            if (cycle == 1) begin
                assert (!write && !halt)
                    else valueError($sformatf("program %0d: write or halt high after reset", prog));
            end
            if ((cycle - 1) % 5 == 0 && cycle < haltCycle) begin
                assert (addr == expFetch[0])
                    else valueError($sformatf("program %0d: fetch from %h, expected %h",
                                              prog, addr, expFetch[0]));
                void'(expFetch.pop_front());
            end
            assert (halt == (cycle >= haltCycle))
                else valueError($sformatf("program %0d: halt is %b in cycle %0d, rises in %0d",
                                          prog, halt, cycle, haltCycle));
            if (write) begin
                assert (expAddr.size() != 0)
                    else valueError($sformatf("program %0d: extra write to %h", prog, addr));
                assert (addr == expAddr[0] && wrData == expData[0])
                    else valueError($sformatf("program %0d: write %h to %h, expected %h to %h",
                                              prog, wrData, addr, expData[0], expAddr[0]));
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
        end
        assert (expAddr.size() == 0)
            else valueError($sformatf("program %0d: %0d expected writes never came",
                                      prog, expAddr.size()));
    endtask

    initial begin
        int count;
        void'($urandom(51970));
        for (int p = 0; p < numPrograms; p++) begin
            expAddr.delete();
            expData.delete();
            expFetch.delete();
            buildProgram();
            runModel(count);
            runOnDut(p, count);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tb.f
hw/epIsaPkg.sv
hw/epCorePkg.sv
hw/epRegFile.sv
hw/epAlu.sv
hw/epSequencer.sv
hw/epOperandPath.sv
hw/epCore.sv
bench/epCore_chk.sv
bench/tbCore.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

logFile=sim.log
failMsg="FAIL: see errors above"

verilator --binary --timing --assert -j 0 --top-module tbCore -f tb.f -o simCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simCore > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -qF "$failMsg" "$logFile"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
